//--- hw/cart_pkg.sv
//====================
// Shared widths, header offsets and enums
// for the cartridge housekeeping block
//====================

package cart_pkg;

	//====================
	// Widths
	//====================
	localparam int ADDR_W = 25;
	localparam int DATA_W = 16;
	localparam int MASK_W = 24;
	localparam int JOY_W  = 12;

	// Download index of a cheat file
	localparam logic [7:0] CODE_INDEX = 8'hff;

	//====================
	// Header offsets
	//====================
	// Copier header in front of the image
	localparam logic [ADDR_W-1:0] COPIER_HDR = 'd512;

	// ROM size field per mapping, RAM size sits 2 above
	localparam logic [ADDR_W-1:0] LOROM_INFO   = 'h7fd6;
	localparam logic [ADDR_W-1:0] HIROM_INFO   = 'hffd6;
	localparam logic [ADDR_W-1:0] EXHIROM_INFO = 'h40ffd6;

	// LLAPI device types of Saturn pads
	localparam logic [7:0] SATURN_TYPE_A = 8'd3;
	localparam logic [7:0] SATURN_TYPE_B = 8'd8;

	//====================
	// Menu choices and states
	//====================
	typedef enum logic [2:0] {
		hdr_auto,
		hdr_none,
		hdr_lorom,
		hdr_hirom,
		hdr_exhirom
	} rom_header_e;

	typedef enum logic [1:0] {
		region_auto,
		region_ntsc,
		region_pal
	} video_region_e;

	typedef enum logic {
		bk_idle,
		bk_transfer
	} bk_state_e;

endpackage

//--- hw/rom_detect.sv
//====================
// ROM header detection
// Picks type, masks and region out of the download
//====================

`timescale 1ns/1ps

module rom_detect
	import cart_pkg::*;
(
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                ioctl_download,
	input  logic [7:0]          ioctl_index,
	input  logic [ADDR_W-1:0]   ioctl_addr,
	input  logic [DATA_W-1:0]   ioctl_dout,
	input  logic                ioctl_wr,
	input  rom_header_e         header_mode,
	input  video_region_e       region_sel,
	output logic                cart_loading,
	output logic [7:0]          rom_type,
	output logic [MASK_W-1:0]   rom_mask,
	output logic [MASK_W-1:0]   ram_mask,
	output logic                pal
);

	logic [3:0]        rom_size;
	logic [3:0]        ram_size;
	logic              rom_region;
	logic              info_mode;
	logic [ADDR_W-1:0] info_addr;
	logic              hdr_wr;

	assign cart_loading = ioctl_download && (ioctl_index != CODE_INDEX);
	assign hdr_wr       = cart_loading && ioctl_wr;

	// Size field location for the forced mappings
	always_comb begin
		info_mode = 1'b1;
		info_addr = '0;
		case (header_mode)
			hdr_lorom:   info_addr = LOROM_INFO + COPIER_HDR;
			hdr_hirom:   info_addr = HIROM_INFO + COPIER_HDR;
			hdr_exhirom: info_addr = EXHIROM_INFO + COPIER_HDR;
			default:     info_mode = 1'b0;
		endcase
	end

	//====================
	// Header fields
	//====================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_type   <= '0;
			rom_size   <= '0;
			ram_size   <= '0;
			rom_region <= 1'b0;
		end else if (hdr_wr) begin
			if (ioctl_addr == '0) begin
				rom_size <= 4'hc;
				ram_size <= 4'h0;
				// Loader puts both sizes in the low byte
				if (header_mode == hdr_auto && ioctl_dout[7:0] != 8'h00) begin
					rom_size <= ioctl_dout[3:0];
					ram_size <= ioctl_dout[7:4];
				end
				case (header_mode)
					hdr_none, hdr_lorom: rom_type <= 8'd0;
					hdr_hirom:           rom_type <= 8'd1;
					hdr_exhirom:         rom_type <= 8'd2;
					default:             rom_type <= ioctl_dout[15:8];
				endcase
			end
			if (ioctl_addr == ADDR_W'(2))
				rom_region <= ioctl_dout[8];
			if (info_mode) begin
				if (ioctl_addr == info_addr)
					rom_size <= ioctl_dout[11:8];
				if (ioctl_addr == info_addr + ADDR_W'(2))
					ram_size <= ioctl_dout[3:0];
			end
		end
	end

	// Sizes are powers of two in 1 KB units
	assign rom_mask = (MASK_W'(1024) << rom_size) - 1'b1;
	assign ram_mask = (ram_size != 4'h0) ? (MASK_W'(1024) << ram_size) - 1'b1 : '0;

	// Region holds while a cart streams in
	always_ff @(posedge clk_sys) begin
		if (!reset)
			pal <= 1'b0;
		else if (!cart_loading)
			pal <= (region_sel == region_auto) ? rom_region : (region_sel == region_pal);
	end

endmodule

//--- hw/cheat_loader.sv
//====================
// Cheat record assembly from eight download words
//====================

`timescale 1ns/1ps

module cheat_loader
	import cart_pkg::*;
(
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                ioctl_download,
	input  logic [7:0]          ioctl_index,
	input  logic [ADDR_W-1:0]   ioctl_addr,
	input  logic [DATA_W-1:0]   ioctl_dout,
	input  logic                ioctl_wr,
	input  logic                cart_loading,
	output logic [31:0]         cheat_flags,
	output logic [31:0]         cheat_addr,
	output logic [31:0]         cheat_compare,
	output logic [31:0]         cheat_replace,
	output logic                cheat_strobe,
	output logic                cheat_clear
);

	logic code_wr;

	assign code_wr = ioctl_download && (ioctl_index == CODE_INDEX) && ioctl_wr;

	// Table is wiped on a new cart or at the start of a cheat file
	assign cheat_clear = cart_loading || (code_wr && ioctl_addr == '0);

	// Fields arrive low word first
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			cheat_flags   <= '0;
			cheat_addr    <= '0;
			cheat_compare <= '0;
			cheat_replace <= '0;
		end else if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  cheat_flags[15:0]    <= ioctl_dout;
				4'd2:  cheat_flags[31:16]   <= ioctl_dout;
				4'd4:  cheat_addr[15:0]     <= ioctl_dout;
				4'd6:  cheat_addr[31:16]    <= ioctl_dout;
				4'd8:  cheat_compare[15:0]  <= ioctl_dout;
				4'd10: cheat_compare[31:16] <= ioctl_dout;
				4'd12: cheat_replace[15:0]  <= ioctl_dout;
				4'd14: cheat_replace[31:16] <= ioctl_dout;
				default: ;
			endcase
		end
	end

	// Last word closes the record
	always_ff @(posedge clk_sys) begin
		if (!reset)
			cheat_strobe <= 1'b0;
		else
			cheat_strobe <= code_wr && (ioctl_addr[3:0] == 4'd14);
	end

endmodule

//--- hw/backup_sync.sv
//====================
// Backup RAM enable, dirty flag and
// SD sector sequencer for load and save
//====================

`timescale 1ns/1ps

module backup_sync
	import cart_pkg::*;
#(
	parameter int LBA_W = 32
) (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                cart_loading,
	input  logic [MASK_W-1:0]   ram_mask,
	input  logic                img_mounted,
	input  logic                img_readonly,
	input  logic                img_present,
	input  logic                bsram_write,
	input  logic                osd_open,
	input  logic                autosave,
	input  logic                bk_load_req,
	input  logic                bk_save_req,
	input  logic                sd_ack,
	output logic [LBA_W-1:0]    sd_lba,
	output logic                sd_rd,
	output logic                sd_wr,
	output logic                bk_loading,
	output logic                bk_busy,
	output logic                bk_pending,
	output logic                bk_enabled
);

	bk_state_e  state;
	logic       loading_d;
	logic       load_r;
	logic       load_d;
	logic       save_r;
	logic       save_d;
	logic       ack_d;
	logic       bk_save;
	logic       start_load;
	logic       start_save;
	logic       last_sector;

	assign bk_busy = (state == bk_transfer);

	// Autosave fires once the menu opens on dirty RAM
	assign bk_save     = bk_save_req || (bk_pending && osd_open && autosave);
	assign start_load  = (load_r && !load_d) ||
	                     (loading_d && !cart_loading && img_present && bk_enabled);
	assign start_save  = save_r && !save_d;
	assign last_sector = (sd_lba >= LBA_W'(ram_mask[MASK_W-1:9]));

	//====================
	// Enable and dirty flag
	//====================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			loading_d  <= 1'b0;
			bk_enabled <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			loading_d <= cart_loading;
			if (!loading_d && cart_loading)
				bk_enabled <= 1'b0;
			// Save image gets mounted near the end of the download
			if (cart_loading && img_mounted && !img_readonly)
				bk_enabled <= |ram_mask;

			if (bk_enabled && !osd_open && bsram_write)
				bk_pending <= 1'b1;
			else if (bk_busy)
				bk_pending <= 1'b0;
		end
	end

	//====================
	// Sector sequencer
	//====================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			state      <= bk_idle;
			load_r     <= 1'b0;
			load_d     <= 1'b0;
			save_r     <= 1'b0;
			save_d     <= 1'b0;
			ack_d      <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			load_r <= bk_load_req && bk_enabled;
			load_d <= load_r;
			save_r <= bk_save && bk_enabled;
			save_d <= save_r;
			ack_d  <= sd_ack;

			// Host took the request
			if (!ack_d && sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				bk_idle: begin
					if (start_load || start_save) begin
						state      <= bk_transfer;
						bk_loading <= start_load;
						sd_lba     <= '0;
						sd_rd      <= start_load;
						sd_wr      <= !start_load;
					end
				end
				bk_transfer: begin
					// Sector done on the falling ack
					if (ack_d && !sd_ack) begin
						if (last_sector) begin
							state      <= bk_idle;
							bk_loading <= 1'b0;
						end else begin
							sd_lba <= sd_lba + 1'b1;
							sd_rd  <= bk_loading;
							sd_wr  <= !bk_loading;
						end
					end
				end
				default: state <= bk_idle;
			endcase
		end
	end

endmodule

//--- hw/pad_mapper.sv
//====================
// LLAPI pad to joystick word mapping
//====================

`timescale 1ns/1ps

module pad_mapper
	import cart_pkg::*;
(
	input  logic [31:0]         llapi_buttons,
	input  logic [7:0]          llapi_type,
	input  logic                llapi_en,
	input  logic                llapi_select,
	input  logic [JOY_W-1:0]    hps_joy,
	output logic [JOY_W-1:0]    joy,
	output logic                menu_combo
);

	logic             saturn;
	logic [JOY_W-1:0] joy_ll;

	assign saturn = (llapi_type == SATURN_TYPE_A) || (llapi_type == SATURN_TYPE_B);

	// Start, select, RT, LT, Y, X, B, A, then d-pad
	always_comb begin
		joy_ll = {
			llapi_buttons[5], llapi_buttons[4],
			llapi_buttons[7], llapi_buttons[6],
			llapi_buttons[2], llapi_buttons[3], llapi_buttons[0], llapi_buttons[1],
			llapi_buttons[27:24]
		};
		// Saturn has no select, so Z takes it and L/R fold onto the shoulders
		if (saturn) begin
			joy_ll[10] = llapi_buttons[6];
			joy_ll[9]  = llapi_buttons[9] | llapi_buttons[7];
			joy_ll[8]  = llapi_buttons[8];
		end
	end

	assign joy = (llapi_en && llapi_select) ? joy_ll : hps_joy;

	// Menu combo works even with the pad unused
	assign menu_combo = llapi_buttons[26] & llapi_buttons[5] & llapi_buttons[0];

endmodule

//--- hw/cart_ctrl_top.sv
//====================
// Cartridge housekeeping top level
// Header detect, cheats, backup sequencing and pad mapping
//====================

`timescale 1ns/1ps

module cart_ctrl_top
	import cart_pkg::*;
#(
	parameter int LBA_W = 32
) (
	input  logic                clk_sys,
	input  logic                reset,

	// Download stream
	input  logic                ioctl_download,
	input  logic [7:0]          ioctl_index,
	input  logic [ADDR_W-1:0]   ioctl_addr,
	input  logic [DATA_W-1:0]   ioctl_dout,
	input  logic                ioctl_wr,

	// Menu
	input  rom_header_e         header_mode,
	input  video_region_e       region_sel,
	input  logic                autosave,
	input  logic                bk_load_req,
	input  logic                bk_save_req,
	input  logic                llapi_select,
	input  logic                osd_open,

	// Save image and system
	input  logic                img_mounted,
	input  logic                img_readonly,
	input  logic                img_present,
	input  logic                bsram_write,
	input  logic                sd_ack,

	// Pads
	input  logic [31:0]         llapi_buttons_a,
	input  logic [31:0]         llapi_buttons_b,
	input  logic [7:0]          llapi_type_a,
	input  logic [7:0]          llapi_type_b,
	input  logic                llapi_en_a,
	input  logic                llapi_en_b,
	input  logic [JOY_W-1:0]    hps_joy_a,
	input  logic [JOY_W-1:0]    hps_joy_b,

	// Cartridge info
	output logic                cart_loading,
	output logic [7:0]          rom_type,
	output logic [MASK_W-1:0]   rom_mask,
	output logic [MASK_W-1:0]   ram_mask,
	output logic                pal,

	// Cheat record
	output logic [31:0]         cheat_flags,
	output logic [31:0]         cheat_addr,
	output logic [31:0]         cheat_compare,
	output logic [31:0]         cheat_replace,
	output logic                cheat_strobe,
	output logic                cheat_clear,

	// SD channel and backup status
	output logic [LBA_W-1:0]    sd_lba,
	output logic                sd_rd,
	output logic                sd_wr,
	output logic                bk_loading,
	output logic                bk_pending,
	output logic                bk_busy,
	output logic                bk_enabled,

	// Mapped joysticks
	output logic [JOY_W-1:0]    joy_a,
	output logic [JOY_W-1:0]    joy_b,
	output logic                menu_combo_a,
	output logic                menu_combo_b
);

	rom_detect i_rom_detect (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.header_mode    (header_mode),
		.region_sel     (region_sel),
		.cart_loading   (cart_loading),
		.rom_type       (rom_type),
		.rom_mask       (rom_mask),
		.ram_mask       (ram_mask),
		.pal            (pal)
	);

	cheat_loader i_cheat_loader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.cart_loading   (cart_loading),
		.cheat_flags    (cheat_flags),
		.cheat_addr     (cheat_addr),
		.cheat_compare  (cheat_compare),
		.cheat_replace  (cheat_replace),
		.cheat_strobe   (cheat_strobe),
		.cheat_clear    (cheat_clear)
	);

	backup_sync #(
		.LBA_W (LBA_W)
	) i_backup_sync (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cart_loading (cart_loading),
		.ram_mask     (ram_mask),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_present  (img_present),
		.bsram_write  (bsram_write),
		.osd_open     (osd_open),
		.autosave     (autosave),
		.bk_load_req  (bk_load_req),
		.bk_save_req  (bk_save_req),
		.sd_ack       (sd_ack),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_loading   (bk_loading),
		.bk_busy      (bk_busy),
		.bk_pending   (bk_pending),
		.bk_enabled   (bk_enabled)
	);

	// One mapper per LLAPI port
	pad_mapper i_pad_mapper_a (
		.llapi_buttons (llapi_buttons_a),
		.llapi_type    (llapi_type_a),
		.llapi_en      (llapi_en_a),
		.llapi_select  (llapi_select),
		.hps_joy       (hps_joy_a),
		.joy           (joy_a),
		.menu_combo    (menu_combo_a)
	);

	pad_mapper i_pad_mapper_b (
		.llapi_buttons (llapi_buttons_b),
		.llapi_type    (llapi_type_b),
		.llapi_en      (llapi_en_b),
		.llapi_select  (llapi_select),
		.hps_joy       (hps_joy_b),
		.joy           (joy_b),
		.menu_combo    (menu_combo_b)
	);

endmodule

//--- tests/tb_cart_ctrl.sv
//====================
// Testbench for the cartridge housekeeping top
// Random stimulus against a reference model
//====================

`timescale 1ns/1ps

module tb_cart_ctrl
	import cart_pkg::*;
;

	// Cycle budget per test plus a margin for the SD ack responder
	localparam int MAX_CYCLES = 16 + 40 * 14 + 20 * 16 + 3 * 16 * 16 + 3 * 14 + 200 * 2 + 1000;

	logic clk_sys;
	logic reset;
	logic ioctl_download, ioctl_wr;
	logic [7:0] ioctl_index;
	logic [ADDR_W-1:0] ioctl_addr;
	logic [DATA_W-1:0] ioctl_dout;
	rom_header_e header_mode;
	video_region_e region_sel;
	logic autosave, bk_load_req, bk_save_req, llapi_select, osd_open;
	logic img_mounted, img_readonly, img_present, bsram_write, sd_ack;
	logic [31:0] llapi_buttons_a, llapi_buttons_b;
	logic [7:0] llapi_type_a, llapi_type_b;
	logic llapi_en_a, llapi_en_b;
	logic [JOY_W-1:0] hps_joy_a, hps_joy_b;
	logic cart_loading, pal;
	logic [7:0] rom_type;
	logic [MASK_W-1:0] rom_mask, ram_mask;
	logic [31:0] cheat_flags, cheat_addr, cheat_compare, cheat_replace;
	logic cheat_strobe, cheat_clear;
	logic [31:0] sd_lba;
	logic sd_rd, sd_wr, bk_loading, bk_pending, bk_busy, bk_enabled;
	logic [JOY_W-1:0] joy_a, joy_b;
	logic menu_combo_a, menu_combo_b;

	// Bookkeeping and model state
	int errors, tests, cycles, strobe_count, sector_count;
	logic [31:0] lfsr;
	logic pal_hold, exp_pal, exp_strobe, exp_clear, exp_loading, rd_prev, wr_prev;
	logic [3:0] m_rom_size, m_ram_size;
	logic [7:0] m_type;
	logic m_region, m_enabled;

	cart_ctrl_top #(.LBA_W(32)) i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	//====================
	// Helpers
	//====================
	// Galois LFSR stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd0000001) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic logic [MASK_W-1:0] mask_of(input logic [3:0] size);
		return (24'd1024 << size) - 24'd1;
	endfunction

	function automatic logic [MASK_W-1:0] exp_ram_mask();
		return (m_ram_size == 4'h0) ? '0 : mask_of(m_ram_size);
	endfunction

	function automatic logic [7:0] pick_type();
		case (rand_bits(2))
			0: return SATURN_TYPE_A;
			1: return SATURN_TYPE_B;
			default: return 8'(rand_bits(8));
		endcase
	endfunction

	// Combo bit on top of the joystick word
	function automatic logic [12:0] map_pad(input logic [31:0] b, input logic [7:0] t,
			input logic en, input logic sel, input logic [11:0] hps);
		logic sat;
		logic se, rt, lt;
		logic [11:0] j;
		sat = (t == SATURN_TYPE_A) || (t == SATURN_TYPE_B);
		se = sat ? b[6] : b[4];
		rt = sat ? (b[9] | b[7]) : b[7];
		lt = sat ? b[8] : b[6];
		j = {b[5], se, rt, lt, b[2], b[3], b[0], b[1], b[27:24]};
		if (!(en && sel))
			j = hps;
		return {b[26] & b[5] & b[0], j};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		errors++;
		$display("error at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
	endtask

	task automatic report_problem(input string msg);
		errors++;
		$display("at %0t ns: %s", $time, msg);
	endtask

	task automatic end_test(input string name, input int start_err);
		tests++;
		$display("test %s finished with %0d errors", name, errors - start_err);
	endtask

	task automatic step;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr = 1'b1;
		step;
		ioctl_wr = 1'b0;
	endtask

	task automatic wait_busy(input logic level);
		while (bk_busy !== level)
			step;
	endtask

	//====================
	// Cart download with model update
	//====================
	task automatic download_cart(input rom_header_e mode, input video_region_e rsel,
			input logic [15:0] w0, input logic mount, input logic ro);
		logic [15:0] w2, f_rom, f_ram;
		logic [ADDR_W-1:0] info;
		int k;
		w2 = 16'(rand_bits(16));
		f_rom = 16'(rand_bits(16));
		f_ram = 16'(rand_bits(16));
		header_mode = mode;
		region_sel = rsel;
		ioctl_index = 8'h00;
		ioctl_download = 1'b1;
		pal_hold = 1'b1;
		m_enabled = 1'b0;

		write_word('0, w0);
		m_rom_size = 4'hc;
		m_ram_size = 4'h0;
		if (mode == hdr_auto && w0[7:0] != 8'h00) begin
			m_rom_size = w0[3:0];
			m_ram_size = w0[7:4];
		end
		case (mode)
			hdr_auto:    m_type = w0[15:8];
			hdr_hirom:   m_type = 8'd1;
			hdr_exhirom: m_type = 8'd2;
			default:     m_type = 8'd0;
		endcase
		write_word(ADDR_W'(2), w2);
		m_region = w2[8];

		// Filler words well below any size field
		for (k = 0; k < 2; k++)
			write_word(ADDR_W'(rand_bits(11) * 2 + 4), 16'(rand_bits(16)));

		if (mode == hdr_lorom || mode == hdr_hirom || mode == hdr_exhirom) begin
			info = (mode == hdr_lorom) ? LOROM_INFO :
			       (mode == hdr_hirom) ? HIROM_INFO : EXHIROM_INFO;
			info = info + COPIER_HDR;
			write_word(info, f_rom);
			m_rom_size = f_rom[11:8];
			write_word(info + ADDR_W'(2), f_ram);
			m_ram_size = f_ram[3:0];
		end

		if (mount) begin
			img_readonly = ro;
			img_mounted = 1'b1;
			step;
			img_mounted = 1'b0;
			if (!ro)
				m_enabled = (m_ram_size != 4'h0);
		end

		ioctl_download = 1'b0;
		pal_hold = 1'b0;
		exp_pal = (rsel == region_auto) ? m_region : (rsel == region_pal);
		step;
		if (rom_type !== m_type)
			report_mismatch("rom_type", m_type, rom_type);
		if (rom_mask !== mask_of(m_rom_size))
			report_mismatch("rom_mask", mask_of(m_rom_size), rom_mask);
		if (ram_mask !== exp_ram_mask())
			report_mismatch("ram_mask", exp_ram_mask(), ram_mask);
		if (pal !== exp_pal)
			report_mismatch("pal", exp_pal, pal);
		if (bk_enabled !== m_enabled)
			report_mismatch("bk_enabled", m_enabled, bk_enabled);
	endtask

	//====================
	// Tests
	//====================
	task automatic test_headers;
		int i, start_err;
		logic [15:0] w0;
		start_err = errors;
		for (i = 0; i < 40; i++) begin
			w0 = 16'(rand_bits(16));
			if (rand_bits(2) == 0)
				w0[7:0] = 8'h00;
			download_cart(rom_header_e'(3'(i % 5)), video_region_e'(2'(rand_bits(2) % 3)),
			              w0, 1'b0, 1'b0);
		end
		end_test("header detection and region", start_err);
	endtask

	task automatic test_cheats;
		int rec, k, start_err;
		logic [15:0] w [8];
		start_err = errors;
		strobe_count = 0;
		ioctl_index = CODE_INDEX;
		ioctl_download = 1'b1;
		for (rec = 0; rec < 20; rec++) begin
			for (k = 0; k < 8; k++) begin
				w[k] = 16'(rand_bits(16));
				write_word(ADDR_W'(rec * 16 + k * 2), w[k]);
				if (k < 7 && rand_bits(1))
					step;
			end
			if (cheat_flags !== {w[1], w[0]})
				report_mismatch("cheat_flags", {w[1], w[0]}, cheat_flags);
			if (cheat_addr !== {w[3], w[2]})
				report_mismatch("cheat_addr", {w[3], w[2]}, cheat_addr);
			if (cheat_compare !== {w[5], w[4]})
				report_mismatch("cheat_compare", {w[5], w[4]}, cheat_compare);
			if (cheat_replace !== {w[7], w[6]})
				report_mismatch("cheat_replace", {w[7], w[6]}, cheat_replace);
			step;
			if (strobe_count != rec + 1)
				report_problem("cheat_strobe count does not match the records written");
		end
		ioctl_download = 1'b0;
		ioctl_index = 8'h00;
		step;
		if (strobe_count != 20)
			report_problem("cheat_strobe did not pulse once per record");
		end_test("cheat records", start_err);
	endtask

	task automatic run_transfer(input logic load);
		int exp_sectors;
		exp_sectors = int'(exp_ram_mask() >> 9) + 1;
		sector_count = 0;
		if (load)
			bk_load_req = 1'b1;
		else
			bk_save_req = 1'b1;
		wait_busy(1'b1);
		bk_load_req = 1'b0;
		bk_save_req = 1'b0;
		if (bk_loading !== load)
			report_mismatch("bk_loading", load, bk_loading);
		wait_busy(1'b0);
		if (sector_count != exp_sectors)
			report_mismatch("sector count", exp_sectors, sector_count);
		if (bk_loading !== 1'b0)
			report_mismatch("bk_loading", 0, bk_loading);
	endtask

	task automatic test_backup;
		int start_err;
		logic [1:0] rs;
		start_err = errors;
		// Small save RAM of 4 to 16 sectors
		rs = 2'(1 + rand_bits(2) % 3);
		img_present = 1'b0;
		download_cart(hdr_auto, region_sel, {8'(rand_bits(8)), 2'b00, rs, 4'(rand_bits(4))},
		              1'b1, 1'b0);
		run_transfer(1'b1);
		run_transfer(1'b0);
		end_test("backup load and save", start_err);
	endtask

	task automatic test_pending;
		int start_err, i;
		start_err = errors;
		// Writes with the menu open leave the flag clear
		osd_open = 1'b1;
		bsram_write = 1'b1;
		step;
		bsram_write = 1'b0;
		step;
		if (bk_pending !== 1'b0)
			report_mismatch("bk_pending", 0, bk_pending);
		osd_open = 1'b0;
		bsram_write = 1'b1;
		step;
		bsram_write = 1'b0;
		if (bk_pending !== 1'b1)
			report_mismatch("bk_pending", 1, bk_pending);

		// Autosave on menu open
		sector_count = 0;
		autosave = 1'b1;
		osd_open = 1'b1;
		wait_busy(1'b1);
		wait_busy(1'b0);
		if (bk_pending !== 1'b0)
			report_mismatch("bk_pending", 0, bk_pending);
		if (sector_count != int'(exp_ram_mask() >> 9) + 1)
			report_mismatch("sector count", int'(exp_ram_mask() >> 9) + 1, sector_count);
		autosave = 1'b0;
		osd_open = 1'b0;

		// Read-only image
		download_cart(hdr_auto, region_sel, 16'(rand_bits(16)) | 16'h0010, 1'b1, 1'b1);
		sector_count = 0;
		bk_load_req = 1'b1;
		bk_save_req = 1'b1;
		for (i = 0; i < 8; i++) begin
			step;
			if (bk_busy !== 1'b0)
				report_mismatch("bk_busy", 0, bk_busy);
		end
		bk_load_req = 1'b0;
		bk_save_req = 1'b0;
		img_readonly = 1'b0;
		if (sector_count != 0)
			report_problem("SD requests issued for a read-only image");
		end_test("dirty flag, autosave and read-only", start_err);
	endtask

	task automatic test_pads;
		int i, start_err;
		logic [12:0] exp_a, exp_b;
		start_err = errors;
		for (i = 0; i < 200; i++) begin
			llapi_buttons_a = rand_bits(32);
			llapi_buttons_b = rand_bits(32);
			llapi_type_a = pick_type();
			llapi_type_b = pick_type();
			llapi_en_a = 1'(rand_bits(1));
			llapi_en_b = 1'(rand_bits(1));
			llapi_select = (rand_bits(2) != 0);
			hps_joy_a = 12'(rand_bits(12));
			hps_joy_b = 12'(rand_bits(12));
			@(negedge clk_sys);
			exp_a = map_pad(llapi_buttons_a, llapi_type_a, llapi_en_a, llapi_select, hps_joy_a);
			exp_b = map_pad(llapi_buttons_b, llapi_type_b, llapi_en_b, llapi_select, hps_joy_b);
			if (joy_a !== exp_a[11:0])
				report_mismatch("joy_a", exp_a[11:0], joy_a);
			if (menu_combo_a !== exp_a[12])
				report_mismatch("menu_combo_a", exp_a[12], menu_combo_a);
			if (joy_b !== exp_b[11:0])
				report_mismatch("joy_b", exp_b[11:0], joy_b);
			if (menu_combo_b !== exp_b[12])
				report_mismatch("menu_combo_b", exp_b[12], menu_combo_b);
			step;
		end
		end_test("pad mapping", start_err);
	endtask

	//====================
	// Per-cycle checks
	//====================
	always @(posedge clk_sys)
		exp_strobe <= reset && ioctl_download && (ioctl_index == CODE_INDEX) &&
		              ioctl_wr && (ioctl_addr[3:0] == 4'd14);

	always @(negedge clk_sys) begin
		if (reset) begin
			exp_loading = ioctl_download && (ioctl_index != CODE_INDEX);
			exp_clear = exp_loading ||
			            (ioctl_download && ioctl_index == CODE_INDEX && ioctl_wr &&
			             ioctl_addr == '0);
			if (cart_loading !== exp_loading)
				report_mismatch("cart_loading", exp_loading, cart_loading);
			if (cheat_clear !== exp_clear)
				report_mismatch("cheat_clear", exp_clear, cheat_clear);
			if (cheat_strobe !== exp_strobe)
				report_mismatch("cheat_strobe", exp_strobe, cheat_strobe);
			if (cheat_strobe)
				strobe_count++;
			if (pal_hold && pal !== exp_pal)
				report_mismatch("pal", exp_pal, pal);
			// New sector request
			if ((sd_rd && !rd_prev) || (sd_wr && !wr_prev)) begin
				if (sd_lba !== sector_count)
					report_mismatch("sd_lba", sector_count, sd_lba);
				if (bk_loading !== sd_rd)
					report_mismatch("bk_loading", sd_rd, bk_loading);
				sector_count++;
			end
		end
		rd_prev = sd_rd;
		wr_prev = sd_wr;
	end

	// Host side of the SD channel
	initial begin : ack_responder
		int delay;
		int hold;
		sd_ack = 1'b0;
		forever begin
			step;
			if (sd_rd || sd_wr) begin
				delay = rand_bits(3);
				repeat (delay)
					step;
				sd_ack = 1'b1;
				hold = 1 + rand_bits(2);
				repeat (hold)
					step;
				sd_ack = 1'b0;
			end
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Done: errors found");
			$finish;
		end
	end

	//====================
	// Main sequence
	//====================
	initial begin
		lfsr = 32'd78997;
		errors = 0;
		tests = 0;
		cycles = 0;
		strobe_count = 0;
		sector_count = 0;
		pal_hold = 1'b0;
		exp_pal = 1'b0;
		m_enabled = 1'b0;
		rd_prev = 1'b0;
		wr_prev = 1'b0;
		reset = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_index = 8'h00;
		ioctl_addr = '0;
		ioctl_dout = '0;
		header_mode = hdr_auto;
		region_sel = region_auto;
		autosave = 1'b0;
		bk_load_req = 1'b0;
		bk_save_req = 1'b0;
		llapi_select = 1'b0;
		osd_open = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_present = 1'b0;
		bsram_write = 1'b0;
		llapi_buttons_a = '0;
		llapi_buttons_b = '0;
		llapi_type_a = '0;
		llapi_type_b = '0;
		llapi_en_a = 1'b0;
		llapi_en_b = 1'b0;
		hps_joy_a = '0;
		hps_joy_b = '0;
		repeat (16) @(posedge clk_sys);
		#1 reset = 1'b1;
		step;

		test_headers;
		test_cheats;
		test_backup;
		test_pending;
		test_pads;

		$display("tests run: %0d, errors: %0d", tests, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- files.f
hw/cart_pkg.sv
hw/rom_detect.sv
hw/cheat_loader.sv
hw/backup_sync.sv
hw/pad_mapper.sv
hw/cart_ctrl_top.sv
tests/tb_cart_ctrl.sv

//--- Bender.yml
package:
  name: cart_ctrl

sources:
  - hw/cart_pkg.sv
  - hw/rom_detect.sv
  - hw/cheat_loader.sv
  - hw/backup_sync.sv
  - hw/pad_mapper.sv
  - hw/cart_ctrl_top.sv
  - target: test
    files:
      - tests/tb_cart_ctrl.sv
